/* lsu_defines.svh */
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Data and address width
`define LSU_XLEN 32

// Data memory of 256 words indexed by address bits [9:2]
`define LSU_DMEM_WORDS 256
`define LSU_DMEM_IDX_W 8

// Completion tag width
`define LSU_TAG_W 4

// Major opcodes
`define LSU_OP_LOAD  7'b0000011
`define LSU_OP_STORE 7'b0100011

// Load funct3 encodings
`define LSU_F3_LB  3'b000
`define LSU_F3_LH  3'b001
`define LSU_F3_LW  3'b010
`define LSU_F3_LBU 3'b100
`define LSU_F3_LHU 3'b101

// Store funct3 encodings
`define LSU_F3_SB 3'b000
`define LSU_F3_SH 3'b001
`define LSU_F3_SW 3'b010

`endif

/* lsu_pkg.sv */
package lsu_pkg;

  // --------------------------------------------------
  // Instruction word views
  // --------------------------------------------------

  // I-type layout as used by loads
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } lsu_itype_t;

  // S-type layout with the immediate split around the register fields
  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } lsu_stype_t;

  // Opcode and funct3 sit at the same bits in both views
  typedef union packed {
    lsu_itype_t itype;
    lsu_stype_t stype;
  } lsu_inst_u;

  // --------------------------------------------------
  // Access size and exception codes
  // --------------------------------------------------

  // Matches funct3[1:0] of the access
  typedef enum logic [1:0] {
    BYTE = 2'd0,
    HALF = 2'd1,
    WORD = 2'd2
  } lsu_size_e;

  typedef enum logic [1:0] {
    NONE        = 2'd0,
    ILLEGAL     = 2'd1,
    LD_MISALIGN = 2'd2,
    ST_MISALIGN = 2'd3
  } lsu_exc_e;

endpackage

/* lsu_decode.sv */
`include "lsu_defines.svh"

module lsu_decode
  import lsu_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic                  i_inst_valid,
  input  logic [31:0]           i_inst,
  input  logic [`LSU_XLEN-1:0]  i_rs1_data,
  input  logic [`LSU_XLEN-1:0]  i_rs2_data,
  input  logic [`LSU_TAG_W-1:0] i_tag,
  output logic                  o_valid,
  output logic                  o_is_store,
  output lsu_size_e             o_size,
  output logic                  o_unsigned,
  output lsu_exc_e              o_exc,
  output logic [31:0]           o_imm,
  output logic [`LSU_XLEN-1:0]  o_rs1_data,
  output logic [`LSU_XLEN-1:0]  o_rs2_data,
  output logic [`LSU_TAG_W-1:0] o_tag
);

  lsu_inst_u   w_inst;
  logic        w_is_store;
  lsu_size_e   w_size;
  logic        w_unsigned;
  lsu_exc_e    w_exc;
  logic [31:0] w_imm;

  assign w_inst = i_inst;

  // Anything not matched below stays ILLEGAL and is neither load nor store
  always_comb begin
    w_is_store = 1'b0;
    w_size     = WORD;
    w_unsigned = 1'b0;
    w_exc      = ILLEGAL;
    w_imm      = '0;
    case (w_inst.itype.opcode)
      `LSU_OP_LOAD: begin
        w_imm = {{20{w_inst.itype.imm[11]}}, w_inst.itype.imm};
        case (w_inst.itype.funct3)
          `LSU_F3_LB, `LSU_F3_LH, `LSU_F3_LW: begin
            w_size = lsu_size_e'(w_inst.itype.funct3[1:0]);
            w_exc  = NONE;
          end
          `LSU_F3_LBU, `LSU_F3_LHU: begin
            w_size     = lsu_size_e'(w_inst.itype.funct3[1:0]);
            w_unsigned = 1'b1;
            w_exc      = NONE;
          end
          default: ;
        endcase
      end
      `LSU_OP_STORE: begin
        w_imm = {{20{w_inst.stype.imm_hi[6]}}, w_inst.stype.imm_hi, w_inst.stype.imm_lo};
        case (w_inst.stype.funct3)
          `LSU_F3_SB, `LSU_F3_SH, `LSU_F3_SW: begin
            w_is_store = 1'b1;
            w_size     = lsu_size_e'(w_inst.stype.funct3[1:0]);
            w_exc      = NONE;
          end
          default: ;
        endcase
      end
      default: ;
    endcase
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_valid    <= 1'b0;
      o_is_store <= 1'b0;
      o_exc      <= NONE;
    end else begin
      o_valid    <= i_inst_valid;
      o_is_store <= i_inst_valid & w_is_store;
      o_exc      <= w_exc;
    end
  end

  // Operands and decoded payload
  always_ff @(posedge i_clk) begin
    if (i_inst_valid) begin
      o_size     <= w_size;
      o_unsigned <= w_unsigned;
      o_imm      <= w_imm;
      o_rs1_data <= i_rs1_data;
      o_rs2_data <= i_rs2_data;
      o_tag      <= i_tag;
    end
  end

endmodule

/* lsu_execute.sv */
`include "lsu_defines.svh"

module lsu_execute
  import lsu_pkg::*;
(
  input  logic                       i_clk,
  input  logic                       i_reset_n,
  input  logic                       i_valid,
  input  logic                       i_is_store,
  input  lsu_size_e                  i_size,
  input  logic                       i_unsigned,
  input  lsu_exc_e                   i_exc,
  input  logic [31:0]                i_imm,
  input  logic [`LSU_XLEN-1:0]       i_rs1_data,
  input  logic [`LSU_XLEN-1:0]       i_rs2_data,
  input  logic [`LSU_TAG_W-1:0]      i_tag,
  output logic                       o_mem_en,
  output logic                       o_mem_we,
  output logic [`LSU_DMEM_IDX_W-1:0] o_mem_index,
  output logic [3:0]                 o_mem_be,
  output logic [`LSU_XLEN-1:0]       o_mem_wdata,
  output logic                       o_res_valid,
  output logic                       o_res_load,
  output lsu_size_e                  o_res_size,
  output logic                       o_res_unsigned,
  output logic [1:0]                 o_res_offset,
  output lsu_exc_e                   o_res_exc,
  output logic [`LSU_TAG_W-1:0]      o_res_tag
);

  logic [`LSU_XLEN-1:0] w_addr;
  logic [1:0]           w_offset;
  logic                 w_misalign;
  lsu_exc_e             w_exc;
  logic                 w_legal;
  logic [3:0]           w_be;

  // --------------------------------------------------
  // Address generation and alignment
  // --------------------------------------------------
  assign w_addr   = i_rs1_data + i_imm;
  assign w_offset = w_addr[1:0];

  assign w_misalign = ((i_size == HALF) && w_addr[0]) ||
                      ((i_size == WORD) && (w_offset != 2'b00));

  // Decode exception wins over misalignment
  assign w_exc = (i_exc != NONE) ? i_exc :
                 w_misalign      ? (i_is_store ? ST_MISALIGN : LD_MISALIGN) :
                                   NONE;

  assign w_legal = i_valid && (w_exc == NONE);

  // --------------------------------------------------
  // Memory request
  // --------------------------------------------------
  always_comb begin
    w_be        = 4'b1111;
    o_mem_wdata = i_rs2_data;
    case (i_size)
      BYTE: begin
        w_be        = 4'b0001 << w_offset;
        o_mem_wdata = {4{i_rs2_data[7:0]}};
      end
      HALF: begin
        w_be        = 4'b0011 << w_offset;
        o_mem_wdata = {2{i_rs2_data[15:0]}};
      end
      default: ;
    endcase
  end

  assign o_mem_en    = w_legal;
  assign o_mem_we    = w_legal && i_is_store;
  assign o_mem_index = w_addr[`LSU_DMEM_IDX_W+1:2];
  assign o_mem_be    = o_mem_we ? w_be : 4'b0000;

  // Side-band toward the result stage in step with the memory read
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_res_valid <= 1'b0;
      o_res_load  <= 1'b0;
    end else begin
      o_res_valid <= i_valid;
      o_res_load  <= i_valid && !i_is_store && (i_exc == NONE);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      o_res_size     <= i_size;
      o_res_unsigned <= i_unsigned;
      o_res_offset   <= w_offset;
      o_res_exc      <= w_exc;
      o_res_tag      <= i_tag;
    end
  end

endmodule

/* lsu_dmem.sv */
`include "lsu_defines.svh"

module lsu_dmem (
  input  logic                       i_clk,
  input  logic                       i_reset_n,
  input  logic                       i_en,
  input  logic                       i_we,
  input  logic [`LSU_DMEM_IDX_W-1:0] i_index,
  input  logic [3:0]                 i_be,
  input  logic [`LSU_XLEN-1:0]       i_wdata,
  input  logic                       i_snoop_valid,
  input  logic [31:0]                i_snoop_addr,
  output logic [`LSU_XLEN-1:0]       o_rdata,
  output logic                       o_snoop_valid,
  output logic [`LSU_XLEN-1:0]       o_snoop_data
);

  logic [`LSU_XLEN-1:0]       r_mem [`LSU_DMEM_WORDS];
  logic [`LSU_DMEM_IDX_W-1:0] w_snoop_index;

  assign w_snoop_index = i_snoop_addr[`LSU_DMEM_IDX_W+1:2];

  // --------------------------------------------------
  // Storage with byte-enabled write
  // --------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int w = 0; w < `LSU_DMEM_WORDS; w++) begin
        r_mem[w] <= '0;
      end
    end else if (i_en && i_we) begin
      for (int b = 0; b < 4; b++) begin
        if (i_be[b]) begin
          r_mem[i_index][8*b +: 8] <= i_wdata[8*b +: 8];
        end
      end
    end
  end

  // Pipeline read port
  // A same-edge write is not visible to this read-first port
  always_ff @(posedge i_clk) begin
    if (i_en && !i_we) begin
      o_rdata <= r_mem[i_index];
    end
  end

  // --------------------------------------------------
  // Snoop read port
  // --------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_snoop_valid <= 1'b0;
    end else begin
      o_snoop_valid <= i_snoop_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_snoop_valid) begin
      o_snoop_data <= r_mem[w_snoop_index];
    end
  end

endmodule

/* lsu_result.sv */
`include "lsu_defines.svh"

module lsu_result
  import lsu_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic                  i_valid,
  input  logic                  i_load,
  input  lsu_size_e             i_size,
  input  logic                  i_unsigned,
  input  logic [1:0]            i_offset,
  input  lsu_exc_e              i_exc,
  input  logic [`LSU_TAG_W-1:0] i_tag,
  input  logic [`LSU_XLEN-1:0]  i_rdata,
  output logic                  o_done_valid,
  output logic [`LSU_TAG_W-1:0] o_done_tag,
  output lsu_exc_e              o_done_exc,
  output logic                  o_wr_valid,
  output logic [`LSU_XLEN-1:0]  o_wr_data
);

  logic [7:0]           w_byte;
  logic [15:0]          w_half;
  logic [`LSU_XLEN-1:0] w_load_data;
  logic                 w_wr;

  // --------------------------------------------------
  // Lane select and extension
  // --------------------------------------------------
  assign w_byte = i_rdata[{i_offset, 3'b000} +: 8];
  assign w_half = i_offset[1] ? i_rdata[`LSU_XLEN-1:16] : i_rdata[15:0];

  always_comb begin
    case (i_size)
      BYTE:    w_load_data = {{(`LSU_XLEN-8){w_byte[7] & ~i_unsigned}}, w_byte};
      HALF:    w_load_data = {{(`LSU_XLEN-16){w_half[15] & ~i_unsigned}}, w_half};
      default: w_load_data = i_rdata;
    endcase
  end

  // Only clean loads write back
  assign w_wr = i_valid && i_load && (i_exc == NONE);

  // --------------------------------------------------
  // Completion report
  // --------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_done_valid <= 1'b0;
      o_wr_valid   <= 1'b0;
    end else begin
      o_done_valid <= i_valid;
      o_wr_valid   <= w_wr;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      o_done_tag <= i_tag;
      o_done_exc <= i_exc;
      o_wr_data  <= w_wr ? w_load_data : '0;
    end
  end

endmodule

/* lsu_top.sv */
`include "lsu_defines.svh"

module lsu_top
  import lsu_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic                  i_inst_valid,
  input  logic [31:0]           i_inst,
  input  logic [`LSU_XLEN-1:0]  i_rs1_data,
  input  logic [`LSU_XLEN-1:0]  i_rs2_data,
  input  logic [`LSU_TAG_W-1:0] i_tag,
  input  logic                  i_snoop_valid,
  input  logic [31:0]           i_snoop_addr,
  output logic                  o_done_valid,
  output logic [`LSU_TAG_W-1:0] o_done_tag,
  output lsu_exc_e              o_done_exc,
  output logic                  o_wr_valid,
  output logic [`LSU_XLEN-1:0]  o_wr_data,
  output logic                  o_snoop_valid,
  output logic [`LSU_XLEN-1:0]  o_snoop_data
);

  // Decode to execute
  logic                       w_dec_valid;
  logic                       w_dec_is_store;
  lsu_size_e                  w_dec_size;
  logic                       w_dec_unsigned;
  lsu_exc_e                   w_dec_exc;
  logic [31:0]                w_dec_imm;
  logic [`LSU_XLEN-1:0]       w_dec_rs1_data;
  logic [`LSU_XLEN-1:0]       w_dec_rs2_data;
  logic [`LSU_TAG_W-1:0]      w_dec_tag;

  // Execute to memory
  logic                       w_mem_en;
  logic                       w_mem_we;
  logic [`LSU_DMEM_IDX_W-1:0] w_mem_index;
  logic [3:0]                 w_mem_be;
  logic [`LSU_XLEN-1:0]       w_mem_wdata;
  logic [`LSU_XLEN-1:0]       w_mem_rdata;

  // Execute to result
  logic                       w_res_valid;
  logic                       w_res_load;
  lsu_size_e                  w_res_size;
  logic                       w_res_unsigned;
  logic [1:0]                 w_res_offset;
  lsu_exc_e                   w_res_exc;
  logic [`LSU_TAG_W-1:0]      w_res_tag;

  lsu_decode u_decode (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_inst_valid (i_inst_valid),
    .i_inst       (i_inst),
    .i_rs1_data   (i_rs1_data),
    .i_rs2_data   (i_rs2_data),
    .i_tag        (i_tag),
    .o_valid      (w_dec_valid),
    .o_is_store   (w_dec_is_store),
    .o_size       (w_dec_size),
    .o_unsigned   (w_dec_unsigned),
    .o_exc        (w_dec_exc),
    .o_imm        (w_dec_imm),
    .o_rs1_data   (w_dec_rs1_data),
    .o_rs2_data   (w_dec_rs2_data),
    .o_tag        (w_dec_tag)
  );

  lsu_execute u_execute (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_valid        (w_dec_valid),
    .i_is_store     (w_dec_is_store),
    .i_size         (w_dec_size),
    .i_unsigned     (w_dec_unsigned),
    .i_exc          (w_dec_exc),
    .i_imm          (w_dec_imm),
    .i_rs1_data     (w_dec_rs1_data),
    .i_rs2_data     (w_dec_rs2_data),
    .i_tag          (w_dec_tag),
    .o_mem_en       (w_mem_en),
    .o_mem_we       (w_mem_we),
    .o_mem_index    (w_mem_index),
    .o_mem_be       (w_mem_be),
    .o_mem_wdata    (w_mem_wdata),
    .o_res_valid    (w_res_valid),
    .o_res_load     (w_res_load),
    .o_res_size     (w_res_size),
    .o_res_unsigned (w_res_unsigned),
    .o_res_offset   (w_res_offset),
    .o_res_exc      (w_res_exc),
    .o_res_tag      (w_res_tag)
  );

  lsu_dmem u_dmem (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_en          (w_mem_en),
    .i_we          (w_mem_we),
    .i_index       (w_mem_index),
    .i_be          (w_mem_be),
    .i_wdata       (w_mem_wdata),
    .i_snoop_valid (i_snoop_valid),
    .i_snoop_addr  (i_snoop_addr),
    .o_rdata       (w_mem_rdata),
    .o_snoop_valid (o_snoop_valid),
    .o_snoop_data  (o_snoop_data)
  );

  lsu_result u_result (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_valid      (w_res_valid),
    .i_load       (w_res_load),
    .i_size       (w_res_size),
    .i_unsigned   (w_res_unsigned),
    .i_offset     (w_res_offset),
    .i_exc        (w_res_exc),
    .i_tag        (w_res_tag),
    .i_rdata      (w_mem_rdata),
    .o_done_valid (o_done_valid),
    .o_done_tag   (o_done_tag),
    .o_done_exc   (o_done_exc),
    .o_wr_valid   (o_wr_valid),
    .o_wr_data    (o_wr_data)
  );

endmodule

/* tb_lsu_top.sv */
`include "lsu_defines.svh"

module tb_lsu_top
  import lsu_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_RAND       = 200;
  localparam int DIRECTED_OPS = 100;
  localparam int WATCHDOG_NS  = (DIRECTED_OPS + N_RAND + 20) * 40 * 4;

  typedef struct {
    logic [`LSU_TAG_W-1:0] tag;
    lsu_exc_e              exc;
    logic                  wr;
    logic [`LSU_XLEN-1:0]  data;
  } done_t;

  logic                  i_clk;
  logic                  i_reset_n;
  logic                  i_inst_valid = 1'b0;
  logic [31:0]           i_inst;
  logic [`LSU_XLEN-1:0]  i_rs1_data;
  logic [`LSU_XLEN-1:0]  i_rs2_data;
  logic [`LSU_TAG_W-1:0] i_tag;
  logic                  i_snoop_valid;
  logic [31:0]           i_snoop_addr;
  logic                  o_done_valid;
  logic [`LSU_TAG_W-1:0] o_done_tag;
  lsu_exc_e              o_done_exc;
  logic                  o_wr_valid;
  logic [`LSU_XLEN-1:0]  o_wr_data;
  logic                  o_snoop_valid;
  logic [`LSU_XLEN-1:0]  o_snoop_data;

  // Architectural view updated at issue
  logic [31:0] shadow_mem [`LSU_DMEM_WORDS];
  // Contents as the array holds them for snoop checks
  logic [31:0] commit_mem [`LSU_DMEM_WORDS];
  logic [2:0]  ld_f3 [5] = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};

  // Expectations driven alongside the DUT inputs
  logic                  exp_valid_d = 1'b0;
  logic [`LSU_TAG_W-1:0] exp_tag_d;
  lsu_exc_e              exp_exc_d = NONE;
  logic                  exp_wr_d = 1'b0;
  logic [31:0]           exp_data_d;
  logic                  st_valid_d = 1'b0;
  logic [7:0]            st_idx_d;
  logic [31:0]           st_word_d;

  done_t                 exp_q [$];
  logic                  head_valid = 1'b0;
  logic [`LSU_TAG_W-1:0] head_tag;
  lsu_exc_e              head_exc;
  logic                  head_wr;
  logic [31:0]           head_data;
  logic [31:0]           snoop_exp;
  logic                  st_pend = 1'b0;
  logic [7:0]            st_pend_idx;
  logic [31:0]           st_pend_word;

  logic [`LSU_TAG_W-1:0] tag = '0;
  int issued = 0;
  int completed = 0;
  int err_count = 0;
  int err_at_start = 0;
  int test_num = 0;
  int pass_tests = 0;
  int fail_tests = 0;
  string test_name;

  lsu_top u_lsu_top (.*);

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired, the run did not complete in time");
    $display("TEST FAILED");
    $finish;
  end

  // --------------------------------------------------
  // Scoreboard bookkeeping
  // --------------------------------------------------
  always @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      exp_q.delete();
      st_pend    = 1'b0;
      head_valid = 1'b0;
    end else begin
      // Snoop sees the array before this edge's write
      if (i_snoop_valid) begin
        snoop_exp = commit_mem[i_snoop_addr[9:2]];
      end
      if (st_pend) begin
        commit_mem[st_pend_idx] = st_pend_word;
      end
      st_pend      = st_valid_d;
      st_pend_idx  = st_idx_d;
      st_pend_word = st_word_d;
      if (o_done_valid && (exp_q.size() > 0)) begin
        void'(exp_q.pop_front());
        completed++;
      end
      if (exp_valid_d) begin
        exp_q.push_back('{exp_tag_d, exp_exc_d, exp_wr_d, exp_data_d});
      end
      head_valid = (exp_q.size() > 0);
      if (head_valid) begin
        head_tag  = exp_q[0].tag;
        head_exc  = exp_q[0].exc;
        head_wr   = exp_q[0].wr;
        head_data = exp_q[0].data;
      end
    end
  end

  task automatic log_mismatch(input string msg);
    err_count++;
    $display("MISMATCH %0t: %s", $time, msg);
  endtask

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  a_done_timing: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_done_valid == $past(i_inst_valid, 3))
    else log_mismatch("done strobe not three cycles after issue");

  a_done_value: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_done_valid |-> head_valid && (o_done_tag == head_tag) && (o_done_exc == head_exc) &&
                     (o_wr_valid == head_wr) && (o_wr_data == head_data))
    else log_mismatch($sformatf("done tag %0d exc %0d wr %0b data %h, expected %0d %0d %0b %h",
      $sampled(o_done_tag), $sampled(o_done_exc), $sampled(o_wr_valid), $sampled(o_wr_data),
      $sampled(head_tag), $sampled(head_exc), $sampled(head_wr), $sampled(head_data)));

  a_wr_quiet: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !o_done_valid |-> !o_wr_valid)
    else log_mismatch("write-back strobe without a completion");

  a_snoop_timing: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_snoop_valid == $past(i_snoop_valid))
    else log_mismatch("snoop response not one cycle after request");

  a_snoop_data: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_snoop_valid |-> (o_snoop_data == snoop_exp))
    else log_mismatch($sformatf("snoop data %h, expected %h",
      $sampled(o_snoop_data), $sampled(snoop_exp)));

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  // One cycle with an optional instruction at addr and an optional snoop at saddr
  task automatic step(input bit do_inst, input logic [6:0] opcode, input logic [2:0] f3,
                      input logic [31:0] addr, input logic [31:0] rs2,
                      input bit do_snoop, input logic [31:0] saddr);
    logic [11:0] imm;
    logic [31:0] rs1;
    logic [31:0] inst;
    logic [31:0] word;
    logic [31:0] ldata;
    logic [7:0]  idx;
    logic [1:0]  off;
    logic        is_ld;
    logic        is_st;
    int          nbytes;
    lsu_exc_e    exc;
    imm    = 12'($urandom);
    rs1    = addr - {{20{imm[11]}}, imm};
    idx    = addr[9:2];
    off    = addr[1:0];
    nbytes = 1 << f3[1:0];
    is_ld  = (opcode == `LSU_OP_LOAD) && (f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5});
    is_st  = (opcode == `LSU_OP_STORE) && (f3 inside {3'd0, 3'd1, 3'd2});
    if (opcode == `LSU_OP_STORE) begin
      inst = {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], opcode};
    end else begin
      inst = {imm, 5'd1, f3, 5'd3, opcode};
    end
    // Unknown encodings take priority over natural alignment
    if (!is_ld && !is_st) begin
      exc = ILLEGAL;
    end else if ((addr & (nbytes - 1)) != 0) begin
      exc = is_st ? ST_MISALIGN : LD_MISALIGN;
    end else begin
      exc = NONE;
    end
    word  = shadow_mem[idx];
    ldata = '0;
    if (is_ld && (exc == NONE)) begin
      ldata = word >> (8 * off);
      if (nbytes == 1) begin
        ldata = f3[2] ? {24'd0, ldata[7:0]} : {{24{ldata[7]}}, ldata[7:0]};
      end else if (nbytes == 2) begin
        ldata = f3[2] ? {16'd0, ldata[15:0]} : {{16{ldata[15]}}, ldata[15:0]};
      end
    end
    if (do_inst && is_st && (exc == NONE)) begin
      for (int b = 0; b < nbytes; b++) begin
        word[8*(off+b) +: 8] = rs2[8*b +: 8];
      end
      shadow_mem[idx] = word;
    end
    @(posedge i_clk);
    i_inst_valid  <= do_inst;
    i_inst        <= inst;
    i_rs1_data    <= rs1;
    i_rs2_data    <= rs2;
    i_tag         <= tag;
    i_snoop_valid <= do_snoop;
    i_snoop_addr  <= saddr;
    exp_valid_d   <= do_inst;
    exp_tag_d     <= tag;
    exp_exc_d     <= exc;
    exp_wr_d      <= is_ld && (exc == NONE);
    exp_data_d    <= ldata;
    st_valid_d    <= do_inst && is_st && (exc == NONE);
    st_idx_d      <= idx;
    st_word_d     <= word;
    if (do_inst) begin
      tag = tag + 1'b1;
      issued++;
    end
  endtask

  task automatic load(input logic [2:0] f3, input logic [31:0] addr);
    step(1'b1, `LSU_OP_LOAD, f3, addr, $urandom, 1'b0, 32'd0);
  endtask

  task automatic store(input logic [2:0] f3, input logic [31:0] addr, input logic [31:0] data);
    step(1'b1, `LSU_OP_STORE, f3, addr, data, 1'b0, 32'd0);
  endtask

  task automatic snoop(input logic [31:0] addr);
    step(1'b0, 7'd0, 3'd0, 32'd0, 32'd0, 1'b1, addr);
  endtask

  task automatic idle(input int n);
    repeat (n) step(1'b0, 7'd0, 3'd0, 32'd0, 32'd0, 1'b0, 32'd0);
  endtask

  task automatic start_test(input string name);
    test_num++;
    test_name    = name;
    err_at_start = err_count;
  endtask

  // Wait for every issued instruction to complete, then report
  task automatic finish_test();
    do begin
      idle(1);
      @(negedge i_clk);
    end while (completed != issued);
    idle(2);
    if (err_count == err_at_start) begin
      pass_tests++;
      $display("test %0d %s: PASS", test_num, test_name);
    end else begin
      fail_tests++;
      $display("test %0d %s: FAIL, %0d errors", test_num, test_name, err_count - err_at_start);
    end
  endtask

  initial begin : stimulus
    logic [31:0] a;
    logic [31:0] s;
    int          r;
    bit          sv;
    void'($urandom(32'ha9f17f70));
    for (int w = 0; w < `LSU_DMEM_WORDS; w++) begin
      shadow_mem[w] = '0;
      commit_mem[w] = '0;
    end
    i_reset_n     <= 1'b0;
    i_inst_valid  <= 1'b0;
    i_inst        <= '0;
    i_rs1_data    <= '0;
    i_rs2_data    <= '0;
    i_tag         <= '0;
    i_snoop_valid <= 1'b0;
    i_snoop_addr  <= '0;
    repeat (2) @(posedge i_clk);
    i_reset_n <= 1'b1;

    start_test("word store and load");
    for (int i = 0; i < 8; i++) begin
      a = $urandom & 32'hffff_fffc;
      store(`LSU_F3_SW, a, $urandom);
      load(`LSU_F3_LW, a);
      idle(1);
      load(`LSU_F3_LW, a);
    end
    finish_test();

    start_test("byte and half loads");
    for (int w = 0; w < 2; w++) begin
      a = 32'h200 + 4 * w;
      store(`LSU_F3_SW, a, (w == 0) ? 32'h80ff_7f01 : $urandom);
      for (int o = 0; o < 4; o++) begin
        load(`LSU_F3_LB, a + o);
        load(`LSU_F3_LBU, a + o);
      end
      for (int o = 0; o < 4; o += 2) begin
        load(`LSU_F3_LH, a + o);
        load(`LSU_F3_LHU, a + o);
      end
    end
    finish_test();

    start_test("byte and half stores");
    a = 32'h300;
    store(`LSU_F3_SW, a, 32'h0123_4567);
    for (int o = 0; o < 4; o++) begin
      store(`LSU_F3_SB, a + o, $urandom);
      load(`LSU_F3_LW, a);
    end
    for (int o = 0; o < 4; o += 2) begin
      store(`LSU_F3_SH, a + o, $urandom);
      load(`LSU_F3_LW, a);
    end
    finish_test();

    start_test("misaligned access");
    a = 32'h340;
    store(`LSU_F3_SW, a, $urandom);
    load(`LSU_F3_LH, a + 1);
    load(`LSU_F3_LH, a + 3);
    for (int o = 1; o < 4; o++) load(`LSU_F3_LW, a + o);
    store(`LSU_F3_SH, a + 1, $urandom);
    store(`LSU_F3_SH, a + 3, $urandom);
    for (int o = 1; o < 4; o++) store(`LSU_F3_SW, a + o, $urandom);
    load(`LSU_F3_LW, a);
    finish_test();

    start_test("illegal encodings");
    a = 32'h380;
    store(`LSU_F3_SW, a, $urandom);
    // Odd addresses show that ILLEGAL outranks misalignment
    step(1'b1, 7'b0110011, 3'd0, a + 1, $urandom, 1'b0, 32'd0);
    step(1'b1, 7'b1111111, 3'd2, a + 2, $urandom, 1'b0, 32'd0);
    for (int f = 3; f < 8; f++) begin
      if ((f != `LSU_F3_LBU) && (f != `LSU_F3_LHU)) begin
        step(1'b1, `LSU_OP_LOAD, 3'(f), a + 3, $urandom, 1'b0, 32'd0);
      end
    end
    for (int f = 3; f < 8; f++) step(1'b1, `LSU_OP_STORE, 3'(f), a + 1, $urandom, 1'b0, 32'd0);
    load(`LSU_F3_LW, a);
    finish_test();

    start_test("snoop port");
    a = 32'h3c0;
    store(`LSU_F3_SW, a, $urandom);
    // First snoop meets the write edge and returns the old word
    snoop(a);
    snoop(a);
    step(1'b1, `LSU_OP_STORE, `LSU_F3_SB, a + 1, $urandom, 1'b1, a);
    snoop(a);
    idle(1);
    snoop(a);
    for (int i = 0; i < N_RAND; i++) begin
      r  = $urandom_range(0, 7);
      a  = 32'h100 + ($urandom_range(0, 7) << 2) + $urandom_range(0, 3);
      s  = 32'h100 + ($urandom_range(0, 7) << 2);
      sv = 1'($urandom_range(0, 1));
      if (r < 3) begin
        step(1'b1, `LSU_OP_LOAD, ld_f3[$urandom_range(0, 4)], a, $urandom, sv, s);
      end else if (r < 6) begin
        step(1'b1, `LSU_OP_STORE, 3'($urandom_range(0, 2)), a, $urandom, sv, s);
      end else begin
        step(1'b0, 7'd0, 3'd0, 32'd0, 32'd0, sv, s);
      end
    end
    finish_test();

    $display("tests passed: %0d, tests failed: %0d, errors: %0d",
             pass_tests, fail_tests, err_count);
    if ((fail_tests == 0) && (err_count == 0)) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+.
lsu_pkg.sv
lsu_decode.sv
lsu_execute.sv
lsu_dmem.sv
lsu_result.sv
lsu_top.sv
tb_lsu_top.sv

/* Bender.yml */
package:
  name: lsu

sources:
  - include_dirs:
      - .
    files:
      - lsu_pkg.sv
      - lsu_decode.sv
      - lsu_execute.sv
      - lsu_dmem.sv
      - lsu_result.sv
      - lsu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_lsu_top.sv
